/* ex_pkg.sv */
package ex_pkg;

    // **********************************************************************
    // data widths
    // **********************************************************************
    localparam int xlen          = 64;
    localparam int word_bits     = 32;
    localparam int inst_bits     = 32;
    localparam int reg_id_bits   = 5;
    localparam int op_code_bits  = 24;
    localparam int alu_mode_bits = 8;
    // rv64 shift amount, six bits of op_b
    localparam int shamt_bits    = 6;

    typedef logic [xlen-1:0]          xlen_t;
    typedef logic [word_bits-1:0]     word_t;
    typedef logic [inst_bits-1:0]     inst_t;
    typedef logic [reg_id_bits-1:0]   reg_id_t;
    typedef logic [op_code_bits-1:0]  op_code_t;
    typedef logic [alu_mode_bits-1:0] alu_mode_t;

    // instruction length, step for the sequential pc
    localparam xlen_t inst_bytes = 64'd4;

    // **********************************************************************
    // alu modes
    // **********************************************************************
    localparam alu_mode_t alu_add  = 8'd0;
    localparam alu_mode_t alu_sub  = 8'd1;
    localparam alu_mode_t alu_slt  = 8'd2;
    localparam alu_mode_t alu_sltu = 8'd3;
    localparam alu_mode_t alu_and  = 8'd4;
    localparam alu_mode_t alu_or   = 8'd6;
    localparam alu_mode_t alu_xor  = 8'd7;
    localparam alu_mode_t alu_sll  = 8'd8;
    localparam alu_mode_t alu_srl  = 8'd9;
    localparam alu_mode_t alu_sra  = 8'd10;

    // **********************************************************************
    // operation codes, decoder numbering
    // **********************************************************************
    // register-register alu
    localparam op_code_t op_add   = 24'h004000;
    localparam op_code_t op_sub   = 24'h005000;
    localparam op_code_t op_sll   = 24'h006000;
    localparam op_code_t op_slt   = 24'h007000;
    localparam op_code_t op_sltu  = 24'h008000;
    localparam op_code_t op_xor   = 24'h009000;
    localparam op_code_t op_srl   = 24'h010000;
    localparam op_code_t op_sra   = 24'h011000;
    localparam op_code_t op_or    = 24'h012000;
    localparam op_code_t op_and   = 24'h013000;
    // word variants
    localparam op_code_t op_addw  = 24'h017000;
    localparam op_code_t op_subw  = 24'h018000;
    localparam op_code_t op_sllw  = 24'h019000;
    localparam op_code_t op_srlw  = 24'h01a000;
    localparam op_code_t op_sraw  = 24'h01b000;
    // upper immediates and jumps
    localparam op_code_t op_lui   = 24'h000100;
    localparam op_code_t op_auipc = 24'h000200;
    localparam op_code_t op_jal   = 24'h000300;
    localparam op_code_t op_jalr  = 24'd4;
    // conditional branches
    localparam op_code_t op_beq   = 24'd5;
    localparam op_code_t op_bne   = 24'd6;
    localparam op_code_t op_blt   = 24'd7;
    localparam op_code_t op_bge   = 24'd8;
    localparam op_code_t op_bltu  = 24'd9;
    localparam op_code_t op_bgeu  = 24'd10;
    // register-immediate alu
    localparam op_code_t op_addi  = 24'd19;
    localparam op_code_t op_slti  = 24'd20;
    localparam op_code_t op_sltiu = 24'd21;
    localparam op_code_t op_xori  = 24'd22;
    localparam op_code_t op_ori   = 24'd23;
    localparam op_code_t op_andi  = 24'd24;
    localparam op_code_t op_addiw = 24'd47;
    // multiply and divide
    localparam op_code_t op_mul   = 24'h01d000;
    localparam op_code_t op_div   = 24'h021000;
    localparam op_code_t op_divu  = 24'h022000;
    localparam op_code_t op_remu  = 24'h024000;
    localparam op_code_t op_mulw  = 24'h025000;
    localparam op_code_t op_divw  = 24'h026000;
    localparam op_code_t op_divuw = 24'h027000;
    localparam op_code_t op_remw  = 24'h028000;
    localparam op_code_t op_remuw = 24'h029000;

endpackage

/* ex_issue_if.sv */
`timescale 1ns/1ps

interface ex_issue_if (
    input logic clk
);
    import ex_pkg::*;

    // one issued instruction, held for a single cycle
    logic      valid;
    xlen_t     pc;
    inst_t     inst;
    op_code_t  op;
    // operands already selected by the decoder
    xlen_t     op_a;
    xlen_t     op_b;
    alu_mode_t alu_mode;
    reg_id_t   rd;

    // issue register drives, execute units only read
    modport stage_reg (output valid, pc, inst, op, op_a, op_b, alu_mode, rd);
    modport unit (input clk, valid, pc, inst, op, op_a, op_b, alu_mode, rd);

endinterface

/* ex_stage_reg.sv */
`timescale 1ns/1ps

module ex_stage_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_in,
    input  ex_pkg::xlen_t     pc_in,
    input  ex_pkg::inst_t     inst_in,
    input  ex_pkg::op_code_t  op_in,
    input  ex_pkg::xlen_t     op_a,
    input  ex_pkg::xlen_t     op_b,
    input  ex_pkg::alu_mode_t alu_mode_in,
    input  ex_pkg::reg_id_t   rd_in,
    ex_issue_if.stage_reg     issue
);

    // **********************************************************************
    // issue register, reloaded every clock, no stall
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            issue.valid    <= 1'b0;
            issue.pc       <= '0;
            issue.inst     <= '0;
            issue.op       <= '0;
            issue.op_a     <= '0;
            issue.op_b     <= '0;
            issue.alu_mode <= '0;
            issue.rd       <= '0;
        end else begin
            // bubbles pass through with valid low
            issue.valid    <= valid_in;
            issue.pc       <= pc_in;
            issue.inst     <= inst_in;
            issue.op       <= op_in;
            issue.op_a     <= op_a;
            issue.op_b     <= op_b;
            issue.alu_mode <= alu_mode_in;
            issue.rd       <= rd_in;
        end
    end

    // nothing may issue out of reset
    a_valid_after_rst: assert property (@(posedge clk) rst |=> !issue.valid)
        else $error("ex_stage_reg: valid high after reset");

endmodule

/* ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    ex_issue_if.unit      issue,
    output ex_pkg::xlen_t alu_result
);
    import ex_pkg::*;

    // shift amount from the low bits of op_b
    logic [shamt_bits-1:0] shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;

    assign shamt       = issue.op_b[shamt_bits-1:0];
    assign lt_signed   = $signed(issue.op_a) < $signed(issue.op_b);
    assign lt_unsigned = issue.op_a < issue.op_b;

    // **********************************************************************
    // mode select
    // **********************************************************************
    always_comb begin
        case (issue.alu_mode)
            // also jal target and auipc, decoder feeds pc and imm
            alu_add: begin
                alu_result = issue.op_a + issue.op_b;
            end
            // beq/bne/blt/bge look at this difference
            alu_sub: begin
                alu_result = issue.op_a - issue.op_b;
            end
            alu_slt: begin
                alu_result = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_and: begin
                alu_result = issue.op_a & issue.op_b;
            end
            alu_or: begin
                alu_result = issue.op_a | issue.op_b;
            end
            alu_xor: begin
                alu_result = issue.op_a ^ issue.op_b;
            end
            alu_sll: begin
                alu_result = issue.op_a << shamt;
            end
            alu_srl: begin
                alu_result = issue.op_a >> shamt;
            end
            // arithmetic, sign bit refills from the left
            alu_sra: begin
                alu_result = $signed(issue.op_a) >>> shamt;
            end
            // mode 5 and anything above 10
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

/* ex_muldiv.sv */
`timescale 1ns/1ps

module ex_muldiv (
    ex_issue_if.unit      issue,
    output ex_pkg::xlen_t mul_result,
    output ex_pkg::xlen_t div_result
);
    import ex_pkg::*;

    // low halves for the word forms
    word_t a_w;
    word_t b_w;
    xlen_t mul_full;
    word_t mul_word;
    // doubleword quotients and remainder
    xlen_t quo_s;
    xlen_t quo_u;
    xlen_t rem_u;
    // word quotients and remainders
    word_t quo_ws;
    word_t quo_wu;
    word_t rem_ws;
    word_t rem_wu;

    assign a_w = issue.op_a[word_bits-1:0];
    assign b_w = issue.op_b[word_bits-1:0];

    // **********************************************************************
    // multiply, low product only
    // **********************************************************************
    assign mul_full   = issue.op_a * issue.op_b;
    assign mul_word   = a_w * b_w;
    // word product zero padded, write-back does the sign extension
    assign mul_result = (issue.op == op_mulw) ? {{(xlen-word_bits){1'b0}}, mul_word} : mul_full;

    // **********************************************************************
    // divide and remainder
    // **********************************************************************
    // div is signed, divu/remu unsigned
    assign quo_s  = $signed(issue.op_a) / $signed(issue.op_b);
    assign quo_u  = issue.op_a / issue.op_b;
    assign rem_u  = issue.op_a % issue.op_b;
    assign quo_ws = $signed(a_w) / $signed(b_w);
    assign quo_wu = a_w / b_w;
    assign rem_ws = $signed(a_w) % $signed(b_w);
    assign rem_wu = a_w % b_w;

    always_comb begin
        case (issue.op)
            op_div:   div_result = quo_s;
            op_divu:  div_result = quo_u;
            op_remu:  div_result = rem_u;
            // word results in the low half
            op_divw:  div_result = {{(xlen-word_bits){1'b0}}, quo_ws};
            op_divuw: div_result = {{(xlen-word_bits){1'b0}}, quo_wu};
            op_remw:  div_result = {{(xlen-word_bits){1'b0}}, rem_ws};
            op_remuw: div_result = {{(xlen-word_bits){1'b0}}, rem_wu};
            default:  div_result = '0;
        endcase
    end

endmodule

/* ex_branch_unit.sv */
`timescale 1ns/1ps

module ex_branch_unit (
    ex_issue_if.unit      issue,
    input  ex_pkg::xlen_t alu_result,
    output ex_pkg::xlen_t dnpc,
    output logic          pc_update
);
    import ex_pkg::*;

    xlen_t imm_b;
    xlen_t snpc;
    xlen_t br_target;
    logic  taken;
    logic  is_flow;

    // b-type immediate, sign from inst[31], bit 0 always zero
    assign imm_b = {{51{issue.inst[31]}}, issue.inst[31], issue.inst[7],
                    issue.inst[30:25], issue.inst[11:8], 1'b0};

    assign snpc      = issue.pc + inst_bytes;
    assign br_target = issue.pc + imm_b;

    // **********************************************************************
    // condition and target
    // **********************************************************************
    always_comb begin
        taken   = 1'b0;
        is_flow = 1'b1;
        dnpc    = snpc;
        case (issue.op)
            // jump targets come from the adder
            op_jal:  dnpc = alu_result;
            op_jalr: dnpc = {alu_result[xlen-1:1], 1'b0};
            // signed branches decoded as op_a - op_b
            op_beq:  taken = (alu_result == '0);
            op_bne:  taken = (alu_result != '0);
            op_blt:  taken = alu_result[xlen-1];
            op_bge:  taken = !alu_result[xlen-1];
            // unsigned ones compare the operands directly
            op_bltu: taken = (issue.op_a < issue.op_b);
            op_bgeu: taken = (issue.op_a >= issue.op_b);
            default: is_flow = 1'b0;
        endcase
        if (taken) begin
            dnpc = br_target;
        end
    end

    // redirect only for a live jump or branch
    assign pc_update = issue.valid & is_flow;

    a_update_valid: assert property (@(posedge issue.clk) pc_update |-> issue.valid)
        else $error("ex_branch_unit: pc_update without valid");

endmodule

/* ex_wb_select.sv */
`timescale 1ns/1ps

module ex_wb_select (
    ex_issue_if.unit        issue,
    input  ex_pkg::xlen_t   alu_result,
    input  ex_pkg::xlen_t   mul_result,
    input  ex_pkg::xlen_t   div_result,
    output logic            reg_wr_en,
    output ex_pkg::reg_id_t reg_wr_id,
    output ex_pkg::xlen_t   reg_wr_value
);
    import ex_pkg::*;

    logic  wr_code;
    // sign extend from bit 31 or from bit 63 of the upper half
    logic  sext_lo;
    logic  sext_hi;
    xlen_t raw_value;
    xlen_t ext_value;

    // **********************************************************************
    // source and extension per code
    // **********************************************************************
    always_comb begin
        wr_code   = 1'b1;
        sext_lo   = 1'b0;
        sext_hi   = 1'b0;
        raw_value = alu_result;
        case (issue.op)
            op_add, op_sub, op_sll, op_slt, op_sltu, op_xor,
            op_srl, op_sra, op_or, op_and, op_auipc,
            op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi: begin
                raw_value = alu_result;
            end
            op_addw, op_subw, op_addiw: begin
                sext_lo = 1'b1;
            end
            // decoder put op_a in the upper half for these
            op_sllw, op_srlw, op_sraw: begin
                sext_hi = 1'b1;
            end
            op_lui: begin
                raw_value = issue.op_a;
            end
            // link address
            op_jal, op_jalr: begin
                raw_value = issue.pc + inst_bytes;
            end
            op_mul: raw_value = mul_result;
            op_mulw: begin
                raw_value = mul_result;
                sext_lo   = 1'b1;
            end
            op_div, op_divu, op_remu: begin
                raw_value = div_result;
            end
            op_divw, op_divuw, op_remw, op_remuw: begin
                raw_value = div_result;
                sext_lo   = 1'b1;
            end
            // branches and unknown codes write nothing
            default: wr_code = 1'b0;
        endcase
    end

    assign ext_value = sext_lo ? {{(xlen-word_bits){raw_value[word_bits-1]}},
                                  raw_value[word_bits-1:0]} :
                       sext_hi ? {{(xlen-word_bits){raw_value[xlen-1]}},
                                  raw_value[xlen-1:word_bits]} :
                       raw_value;

    // bubble gives all zero
    assign reg_wr_en    = issue.valid & wr_code;
    assign reg_wr_id    = issue.valid ? issue.rd : '0;
    assign reg_wr_value = issue.valid ? ext_value : '0;

    a_wr_valid: assert property (@(posedge issue.clk) reg_wr_en |-> issue.valid)
        else $error("ex_wb_select: reg_wr_en without valid");

endmodule

/* ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_in,
    input  ex_pkg::xlen_t     pc_in,
    input  ex_pkg::inst_t     inst_in,
    input  ex_pkg::op_code_t  op_in,
    input  ex_pkg::xlen_t     op_a,
    input  ex_pkg::xlen_t     op_b,
    input  ex_pkg::alu_mode_t alu_mode_in,
    input  ex_pkg::reg_id_t   rd_in,
    output logic              valid_out,
    output ex_pkg::xlen_t     pc_out,
    output ex_pkg::inst_t     inst_out,
    output logic              reg_wr_en,
    output ex_pkg::reg_id_t   reg_wr_id,
    output ex_pkg::xlen_t     reg_wr_value,
    output ex_pkg::xlen_t     dnpc,
    output logic              pc_update
);
    import ex_pkg::*;

    xlen_t alu_result;
    xlen_t mul_result;
    xlen_t div_result;

    // **********************************************************************
    // issue register, then combinational units on its fields
    // **********************************************************************
    ex_issue_if issue_bus (.clk(clk));

    ex_stage_reg u_stage_reg (
        .clk(clk), .rst(rst), .valid_in(valid_in), .pc_in(pc_in), .inst_in(inst_in),
        .op_in(op_in), .op_a(op_a), .op_b(op_b), .alu_mode_in(alu_mode_in),
        .rd_in(rd_in), .issue(issue_bus.stage_reg)
    );

    ex_alu u_alu (.issue(issue_bus.unit), .alu_result(alu_result));

    ex_muldiv u_muldiv (
        .issue(issue_bus.unit), .mul_result(mul_result), .div_result(div_result)
    );

    ex_branch_unit u_branch (
        .issue(issue_bus.unit), .alu_result(alu_result), .dnpc(dnpc), .pc_update(pc_update)
    );

    ex_wb_select u_wb_select (
        .issue(issue_bus.unit), .alu_result(alu_result), .mul_result(mul_result),
        .div_result(div_result), .reg_wr_en(reg_wr_en), .reg_wr_id(reg_wr_id),
        .reg_wr_value(reg_wr_value)
    );

    // pass-along to write-back stage
    assign valid_out = issue_bus.valid;
    assign pc_out    = issue_bus.pc;
    assign inst_out  = issue_bus.inst;

endmodule

/* ex_checker.sv */
`timescale 1ns/1ps

module ex_checker (
    input  logic            clk,
    input  logic            rst,
    // watched dut outputs
    input  logic            valid_out,
    input  ex_pkg::xlen_t   pc_out,
    input  ex_pkg::inst_t   inst_out,
    input  logic            reg_wr_en,
    input  ex_pkg::reg_id_t reg_wr_id,
    input  ex_pkg::xlen_t   reg_wr_value,
    input  ex_pkg::xlen_t   dnpc,
    input  logic            pc_update,
    // expected values, presented together with the stimulus
    input  logic            exp_active,
    input  ex_pkg::xlen_t   exp_pc,
    input  ex_pkg::inst_t   exp_inst,
    input  logic            exp_wr_en,
    input  ex_pkg::reg_id_t exp_rd,
    input  ex_pkg::xlen_t   exp_value,
    input  logic            exp_pc_update,
    input  ex_pkg::xlen_t   exp_dnpc,
    output int              error_count,
    output int              check_count
);
    import ex_pkg::*;

    int      errors = 0;
    int      checks = 0;
    // expected values lined up with the one-cycle stage latency
    logic    act_q;
    xlen_t   pc_q;
    inst_t   inst_q;
    logic    wr_en_q;
    reg_id_t rd_q;
    xlen_t   value_q;
    logic    pc_update_q;
    xlen_t   dnpc_q;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare_value(input string name, input xlen_t actual, input xlen_t expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("CHECK FAILED %s: expected %h, actual %h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("CHECK FAILED %s: expected %h, actual %h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // **********************************************************************
    // delay line for the expected values
    // **********************************************************************
    always @(posedge clk) begin
        if (rst) begin
            act_q       <= 1'b0;
            pc_q        <= '0;
            inst_q      <= '0;
            wr_en_q     <= 1'b0;
            rd_q        <= '0;
            value_q     <= '0;
            pc_update_q <= 1'b0;
            dnpc_q      <= '0;
        end else begin
            act_q       <= exp_active;
            pc_q        <= exp_pc;
            inst_q      <= exp_inst;
            wr_en_q     <= exp_wr_en;
            rd_q        <= exp_rd;
            value_q     <= exp_value;
            pc_update_q <= exp_pc_update;
            dnpc_q      <= exp_dnpc;
        end
    end

    // **********************************************************************
    // compare in the middle of the cycle, outputs settled by then
    // **********************************************************************
    always @(negedge clk) begin
        if (!rst) begin
            if (act_q) begin
                compare_bit("valid_out", valid_out, 1'b1);
                // pass-along fields of the issued instruction
                compare_value("pc_out", pc_out, pc_q);
                compare_value("inst_out", xlen_t'(inst_out), xlen_t'(inst_q));
                compare_bit("reg_wr_en", reg_wr_en, wr_en_q);
                compare_bit("pc_update", pc_update, pc_update_q);
                // id and value only mean something on a write
                if (wr_en_q) begin
                    compare_value("reg_wr_id", xlen_t'(reg_wr_id), xlen_t'(rd_q));
                    compare_value("reg_wr_value", reg_wr_value, value_q);
                end
                if (pc_update_q) begin
                    compare_value("dnpc", dnpc, dnpc_q);
                end
            end else begin
                // bubble, or right after reset: everything quiet
                compare_bit("valid_out", valid_out, 1'b0);
                compare_bit("reg_wr_en", reg_wr_en, 1'b0);
                compare_bit("pc_update", pc_update, 1'b0);
                compare_value("reg_wr_id", xlen_t'(reg_wr_id), '0);
                compare_value("reg_wr_value", reg_wr_value, '0);
            end
        end
    end

endmodule

/* tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;

    // b-type encodings, offset +16 and offset -8
    localparam inst_t br_fwd16 = 32'h0000_0863;
    localparam inst_t br_back8 = 32'hFE00_0CE3;

    typedef struct packed {
        logic      valid;
        op_code_t  op;
        alu_mode_t mode;
        xlen_t     a;
        xlen_t     b;
        xlen_t     pc;
        inst_t     inst;
        reg_id_t   rd;
        logic      wr_en;
        xlen_t     value;
        logic      pc_upd;
        xlen_t     dnpc;
    } row_t;

    logic      clk;
    logic      rst;
    logic      valid_in;
    xlen_t     pc_in;
    inst_t     inst_in;
    op_code_t  op_in;
    xlen_t     op_a;
    xlen_t     op_b;
    alu_mode_t alu_mode_in;
    reg_id_t   rd_in;
    logic      valid_out;
    xlen_t     pc_out;
    inst_t     inst_out;
    logic      reg_wr_en;
    reg_id_t   reg_wr_id;
    xlen_t     reg_wr_value;
    xlen_t     dnpc;
    logic      pc_update;
    // expected values handed to the checker
    logic      exp_active;
    xlen_t     exp_pc;
    inst_t     exp_inst;
    logic      exp_wr_en;
    reg_id_t   exp_rd;
    xlen_t     exp_value;
    logic      exp_pc_update;
    xlen_t     exp_dnpc;
    int        error_count;
    int        check_count;

    row_t      rows[$];
    op_code_t  rand_ops[5]   = '{op_add, op_sub, op_xor, op_sltu, op_mul};
    alu_mode_t rand_modes[5] = '{alu_add, alu_sub, alu_xor, alu_sltu, alu_add};
    int        cycle_count   = 0;
    int        timeout_limit = 1000;

    ex_stage UUT (
        .clk(clk), .rst(rst), .valid_in(valid_in), .pc_in(pc_in), .inst_in(inst_in),
        .op_in(op_in), .op_a(op_a), .op_b(op_b), .alu_mode_in(alu_mode_in), .rd_in(rd_in),
        .valid_out(valid_out), .pc_out(pc_out), .inst_out(inst_out), .reg_wr_en(reg_wr_en),
        .reg_wr_id(reg_wr_id), .reg_wr_value(reg_wr_value), .dnpc(dnpc), .pc_update(pc_update)
    );

    ex_checker u_checker (
        .clk(clk), .rst(rst), .valid_out(valid_out), .pc_out(pc_out), .inst_out(inst_out),
        .reg_wr_en(reg_wr_en), .reg_wr_id(reg_wr_id), .reg_wr_value(reg_wr_value),
        .dnpc(dnpc), .pc_update(pc_update), .exp_active(exp_active), .exp_pc(exp_pc),
        .exp_inst(exp_inst), .exp_wr_en(exp_wr_en), .exp_rd(exp_rd), .exp_value(exp_value),
        .exp_pc_update(exp_pc_update), .exp_dnpc(exp_dnpc), .error_count(error_count),
        .check_count(check_count)
    );

    always #2 clk = ~clk;

    // expected write value for the random block
    function automatic xlen_t expect_value(input op_code_t op, input xlen_t a, input xlen_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            op_sltu: return (a < b) ? 64'd1 : 64'd0;
            op_mul:  return a * b;
            default: return '0;
        endcase
    endfunction

    task automatic add_row(input logic valid, input op_code_t op, input alu_mode_t mode,
                           input xlen_t a, input xlen_t b, input xlen_t pc, input inst_t inst,
                           input reg_id_t rd, input logic wr_en, input xlen_t value,
                           input logic pc_upd, input xlen_t dnpc_exp);
        row_t r;
        r = '{valid, op, mode, a, b, pc, inst, rd, wr_en, value, pc_upd, dnpc_exp};
        rows.push_back(r);
    endtask

    // plain register write, no redirect
    task automatic write_row(input op_code_t op, input alu_mode_t mode, input xlen_t a,
                             input xlen_t b, input reg_id_t rd, input xlen_t value);
        add_row(1'b1, op, mode, a, b, 64'h0, 32'h0, rd, 1'b1, value, 1'b0, 64'h0);
    endtask

    // branch: operands go through the subtract
    task automatic branch_row(input op_code_t op, input xlen_t a, input xlen_t b,
                              input xlen_t pc, input inst_t inst, input xlen_t target);
        add_row(1'b1, op, alu_sub, a, b, pc, inst, 5'd0, 1'b0, 64'h0, 1'b1, target);
    endtask

    task automatic add_random_rows(input int count);
        xlen_t a;
        xlen_t b;
        int    k;
        for (int i = 0; i < count; i++) begin
            a[63:32] = $urandom;
            a[31:0]  = $urandom;
            b[63:32] = $urandom;
            b[31:0]  = $urandom;
            k = $urandom % 5;
            write_row(rand_ops[k], rand_modes[k], a, b, reg_id_t'(i % 31 + 1),
                      expect_value(rand_ops[k], a, b));
        end
    endtask

    task automatic apply_row(input row_t r);
        valid_in      = r.valid;
        pc_in         = r.pc;
        inst_in       = r.inst;
        op_in         = r.op;
        op_a          = r.a;
        op_b          = r.b;
        alu_mode_in   = r.mode;
        rd_in         = r.rd;
        exp_active    = r.valid;
        exp_pc        = r.pc;
        exp_inst      = r.inst;
        exp_wr_en     = r.wr_en;
        exp_rd        = r.rd;
        exp_value     = r.value;
        exp_pc_update = r.pc_upd;
        exp_dnpc      = r.dnpc;
    endtask

    task automatic drive_idle();
        row_t r;
        r = '0;
        apply_row(r);
    endtask

    // **********************************************************************
    // stimulus table
    // **********************************************************************
    task automatic build_table();
        // alu, register and immediate
        write_row(op_add, alu_add, 64'd5, 64'd7, 5'd1, 64'd12);
        write_row(op_sub, alu_sub, 64'd5, 64'd7, 5'd2, 64'hFFFF_FFFF_FFFF_FFFE);
        write_row(op_slt, alu_slt, -64'd1, 64'd1, 5'd3, 64'd1);
        write_row(op_sltu, alu_sltu, -64'd1, 64'd1, 5'd4, 64'd0);
        write_row(op_sra, alu_sra, 64'h8000_0000_0000_0000, 64'd4, 5'd5, 64'hF800_0000_0000_0000);
        write_row(op_srl, alu_srl, 64'h8000_0000_0000_0000, 64'd4, 5'd6, 64'h0800_0000_0000_0000);
        // only the low six bits of op_b shift
        write_row(op_sll, alu_sll, 64'd1, 64'h43, 5'd7, 64'd8);
        write_row(op_xor, alu_xor, 64'hFF00, 64'h0FF0, 5'd8, 64'hF0F0);
        write_row(op_or, alu_or, 64'hF0, 64'h0F, 5'd9, 64'hFF);
        write_row(op_and, alu_and, 64'hF0F0, 64'hFF00, 5'd10, 64'hF000);
        write_row(op_addi, alu_add, 64'd100, -64'd4, 5'd11, 64'd96);
        write_row(op_slti, alu_slt, -64'd5, 64'd3, 5'd12, 64'd1);
        write_row(op_sltiu, alu_sltu, -64'd5, 64'd3, 5'd13, 64'd0);
        write_row(op_xori, alu_xor, 64'h1234, -64'd1, 5'd14, 64'hFFFF_FFFF_FFFF_EDCB);
        write_row(op_ori, alu_or, 64'h10, 64'h1, 5'd15, 64'h11);
        write_row(op_andi, alu_and, 64'hFF, 64'hF, 5'd16, 64'hF);
        write_row(op_auipc, alu_add, 64'h1000, 64'h5000, 5'd17, 64'h6000);
        // word forms, shifts carry op_a in the upper half
        write_row(op_addw, alu_add, 64'h7FFF_FFFF, 64'd1, 5'd18, 64'hFFFF_FFFF_8000_0000);
        write_row(op_subw, alu_sub, 64'd0, 64'd1, 5'd19, 64'hFFFF_FFFF_FFFF_FFFF);
        write_row(op_addiw, alu_add, 64'h1_0000_0005, 64'd3, 5'd20, 64'd8);
        write_row(op_sllw, alu_sll, 64'h1_0000_0000, 64'd31, 5'd21, 64'hFFFF_FFFF_8000_0000);
        write_row(op_srlw, alu_srl, 64'h8000_0000_0000_0000, 64'd4, 5'd22, 64'h0800_0000);
        write_row(op_sraw, alu_sra, 64'h8000_0000_0000_0000, 64'd4, 5'd23, 64'hFFFF_FFFF_F800_0000);
        // multiply and divide
        write_row(op_mul, alu_add, 64'd3, -64'd2, 5'd24, 64'hFFFF_FFFF_FFFF_FFFA);
        write_row(op_mulw, alu_add, 64'hABCD_0000_4000_0000, 64'd2, 5'd25, 64'hFFFF_FFFF_8000_0000);
        write_row(op_div, alu_add, -64'd20, 64'd3, 5'd26, 64'hFFFF_FFFF_FFFF_FFFA);
        write_row(op_divu, alu_add, 64'd100, 64'd7, 5'd27, 64'd14);
        write_row(op_remu, alu_add, 64'd100, 64'd7, 5'd28, 64'd2);
        write_row(op_divw, alu_add, 64'h1_FFFF_FFF0, 64'd5, 5'd29, 64'hFFFF_FFFF_FFFF_FFFD);
        write_row(op_divuw, alu_add, 64'hFFFF_FFF0, 64'h10, 5'd30, 64'h0FFF_FFFF);
        write_row(op_remw, alu_add, 64'hFFFF_FFEF, 64'd5, 5'd31, 64'hFFFF_FFFF_FFFF_FFFE);
        write_row(op_remuw, alu_add, 64'h8000_0005, 64'hFFFF_FFFF, 5'd1, 64'hFFFF_FFFF_8000_0005);
        write_row(op_lui, alu_add, 64'hFFFF_FFFF_ABCD_E000, 64'd0, 5'd2, 64'hFFFF_FFFF_ABCD_E000);
        // jal, a bubble holding a jal, then jalr with an odd target
        add_row(1'b1, op_jal, alu_add, 64'h2000, 64'h100, 64'h2000, 32'h0, 5'd1,
                1'b1, 64'h2004, 1'b1, 64'h2100);
        add_row(1'b0, op_jal, alu_add, 64'h2100, 64'h40, 64'h2100, 32'h0, 5'd3,
                1'b0, 64'h0, 1'b0, 64'h0);
        add_row(1'b1, op_jalr, alu_add, 64'h4001, 64'h10, 64'h3000, 32'h0, 5'd1,
                1'b1, 64'h3004, 1'b1, 64'h4010);
        // branches, taken then not taken
        branch_row(op_beq, 64'd5, 64'd5, 64'h1000, br_fwd16, 64'h1010);
        branch_row(op_beq, 64'd5, 64'd6, 64'h1100, br_fwd16, 64'h1104);
        branch_row(op_bne, 64'd1, 64'd2, 64'h1200, br_back8, 64'h11F8);
        branch_row(op_bne, 64'd3, 64'd3, 64'h1300, br_back8, 64'h1304);
        branch_row(op_blt, -64'd1, 64'd1, 64'h1400, br_fwd16, 64'h1410);
        branch_row(op_blt, 64'd2, 64'd1, 64'h1500, br_fwd16, 64'h1504);
        branch_row(op_bge, 64'd1, -64'd1, 64'h1600, br_back8, 64'h15F8);
        branch_row(op_bge, -64'd3, 64'd0, 64'h1700, br_back8, 64'h1704);
        branch_row(op_bltu, 64'd1, -64'd1, 64'h1800, br_fwd16, 64'h1810);
        branch_row(op_bltu, -64'd1, 64'd1, 64'h1900, br_fwd16, 64'h1904);
        branch_row(op_bgeu, -64'd1, 64'd1, 64'h1A00, br_back8, 64'h19F8);
        branch_row(op_bgeu, 64'd1, 64'd2, 64'h1B00, br_back8, 64'h1B04);
    endtask

    // **********************************************************************
    // main sequence
    // **********************************************************************
    initial begin
        void'($urandom(32'h1702));
        clk = 1'b0;
        rst = 1'b1;
        drive_idle();
        build_table();
        add_random_rows(20);
        timeout_limit = rows.size() + 8 + 20;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        // one quiet cycle so the checker sees the reset values
        @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1;
            apply_row(rows[i]);
        end
        @(posedge clk);
        #1;
        drive_idle();
        repeat (3) @(posedge clk);
        if (check_count == 0) begin
            $display("no output was compared during the run");
        end
        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0 && check_count > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // run limit from table length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: stimulus still running after %0d cycles", cycle_count);
            $display("errors: %0d, checks: %0d", error_count, check_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

/* all.f */
ex_pkg.sv
ex_issue_if.sv
ex_stage_reg.sv
ex_alu.sv
ex_muldiv.sv
ex_branch_unit.sv
ex_wb_select.sv
ex_stage.sv
ex_checker.sv
tb_ex_stage.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_ex_stage
FILELIST := all.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
